// ==== design/be_merge.sv ====
`timescale 1ns/1ps

module be_merge (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  mem_bus_pkg::be_req_t  d_req_i,
   input  mem_bus_pkg::be_req_t  i_req_i,
   output mem_bus_pkg::be_resp_t d_resp_o,
   output mem_bus_pkg::be_resp_t i_resp_o,
   output mem_bus_pkg::be_req_t  m_req_o,
   input  mem_bus_pkg::be_resp_t m_resp_i,
   input  logic                  invalidate_i,
   output logic                  inval_o
);

   logic busy_q;    // Grant locked until ack
   logic owner_q;   // 1 when the instruction cache holds the bus
   logic sel_i;
   logic pend_q;    // Invalidate waiting for an idle back end

   // Data cache wins when the bus is free
   assign sel_i   = busy_q ? owner_q : ~d_req_i.valid;
   assign m_req_o = sel_i ? i_req_i : d_req_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q  <= 1'b0;
         owner_q <= 1'b0;
      end else if (m_resp_i.ack) begin
         busy_q <= 1'b0;
      end else if (m_req_o.valid) begin
         busy_q  <= 1'b1;
         owner_q <= sel_i;
      end
   end

   // Ack goes to the owner only
   always_comb begin
      d_resp_o.ack   = m_resp_i.ack & ~sel_i;
      d_resp_o.rdata = m_resp_i.rdata;
      i_resp_o.ack   = m_resp_i.ack & sel_i;
      i_resp_o.rdata = m_resp_i.rdata;
   end

   // Never flush while either cache is talking to memory
   assign inval_o = pend_q & ~d_req_i.valid & ~i_req_i.valid;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         pend_q <= 1'b0;
      end else if (invalidate_i) begin
         pend_q <= 1'b1;
      end else if (inval_o) begin
         pend_q <= 1'b0;
      end
   end

endmodule

// ==== design/cache_ctrl_pkg.sv ====
`include "ext_mem_consts.svh"

package cache_ctrl_pkg;

   // Control registers, word aligned in the control space
   typedef enum logic [1:0] {
      CTRL_INVALIDATE = 2'd0,   // Write only
      CTRL_HITS       = 2'd1,
      CTRL_MISSES     = 2'd2
   } ctrl_sel_e;

   // Address as seen by the caches
   typedef struct packed {
      logic                         space;   // 0 memory, 1 cache control
      logic [`EXT_MEM_TAG_W-1:0]    tag;
      logic [`EXT_MEM_INDEX_W-1:0]  index;
      logic [`EXT_MEM_OFFSET_W-1:0] woff;
      logic [`EXT_MEM_BOFF_W-1:0]   boff;
   } mem_addr_t;

   // Address as seen by the control registers
   typedef struct packed {
      logic                                      space;
      logic [`EXT_MEM_ADDR_W-`EXT_MEM_BOFF_W-4:0] unused;
      ctrl_sel_e                                 sel;
      logic [`EXT_MEM_BOFF_W-1:0]                boff;
   } ctrl_addr_t;

   typedef union packed {
      mem_addr_t  mem;
      ctrl_addr_t ctrl;
   } daddr_u;

   typedef logic [`EXT_MEM_CNT_W-1:0] cnt_t;

endpackage

// ==== design/dbus_decode.sv ====
`timescale 1ns/1ps
`include "ext_mem_consts.svh"

module dbus_decode (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  mem_bus_pkg::fe_req_t  dreq_i,
   output mem_bus_pkg::fe_resp_t dresp_o,
   output mem_bus_pkg::fe_req_t  creq_o,
   input  mem_bus_pkg::fe_resp_t cresp_i,
   input  logic                  hit_i,
   input  logic                  miss_i,
   output logic                  invalidate_o
);

   cache_ctrl_pkg::daddr_u     daddr;
   cache_ctrl_pkg::cnt_t       hits_q;
   cache_ctrl_pkg::cnt_t       misses_q;
   cache_ctrl_pkg::cnt_t       sel_cnt;
   logic                       ctrl_req;
   logic                       ctrl_ack_q;
   logic [`EXT_MEM_DATA_W-1:0] ctrl_rdata_q;

   assign daddr    = dreq_i.addr;
   // No new control access during our own ack cycle
   assign ctrl_req = dreq_i.valid & daddr.ctrl.space & ~ctrl_ack_q;

   always_comb begin
      creq_o       = dreq_i;
      creq_o.valid = dreq_i.valid & ~daddr.mem.space;   // Memory space only
   end

   always_comb begin
      case (daddr.ctrl.sel)
         cache_ctrl_pkg::CTRL_HITS:   sel_cnt = hits_q;
         cache_ctrl_pkg::CTRL_MISSES: sel_cnt = misses_q;
         default:                     sel_cnt = '0;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ctrl_ack_q   <= 1'b0;
         invalidate_o <= 1'b0;
      end else begin
         ctrl_ack_q   <= ctrl_req;
         invalidate_o <= ctrl_req & (|dreq_i.wstrb) &
                         (daddr.ctrl.sel == cache_ctrl_pkg::CTRL_INVALIDATE);
      end
   end

   always_ff @(posedge clk_i) begin
      if (ctrl_req) begin
         ctrl_rdata_q <= {{(`EXT_MEM_DATA_W - `EXT_MEM_CNT_W){1'b0}}, sel_cnt};
      end
   end

   // Data cache event counters
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         hits_q   <= '0;
         misses_q <= '0;
      end else begin
         if (hit_i) hits_q <= hits_q + 1'b1;
         if (miss_i) misses_q <= misses_q + 1'b1;
      end
   end

   always_comb begin
      if (ctrl_ack_q) begin
         dresp_o.ack   = 1'b1;
         dresp_o.rdata = ctrl_rdata_q;
      end else begin
         dresp_o = cresp_i;
      end
   end

endmodule

// ==== design/ext_mem.sv ====
`timescale 1ns/1ps

module ext_mem (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  mem_bus_pkg::fe_req_t  i_req_i,
   input  mem_bus_pkg::fe_req_t  d_req_i,
   output mem_bus_pkg::fe_resp_t i_resp_o,
   output mem_bus_pkg::fe_resp_t d_resp_o,
   output mem_bus_pkg::be_req_t  m_req_o,
   input  mem_bus_pkg::be_resp_t m_resp_i
);

   // Data cache front end, behind the decoder
   mem_bus_pkg::fe_req_t  dc_req;
   mem_bus_pkg::fe_resp_t dc_resp;

   // Cache back ends
   mem_bus_pkg::be_req_t  ic_be_req;
   mem_bus_pkg::be_resp_t ic_be_resp;
   mem_bus_pkg::be_req_t  dc_be_req;
   mem_bus_pkg::be_resp_t dc_be_resp;

   logic dc_hit;
   logic dc_miss;
   logic invalidate;   // Pulse from the control register
   logic inval;        // Released to both caches

   dbus_decode dbus_decode (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .dreq_i       (d_req_i),
      .dresp_o      (d_resp_o),
      .creq_o       (dc_req),
      .cresp_i      (dc_resp),
      .hit_i        (dc_hit),
      .miss_i       (dc_miss),
      .invalidate_o (invalidate)
   );

   wt_cache icache (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (i_req_i),
      .resp_o    (i_resp_o),
      .be_req_o  (ic_be_req),
      .be_resp_i (ic_be_resp),
      .inval_i   (inval),
      .hit_o     (),
      .miss_o    ()
   );

   wt_cache dcache (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (dc_req),
      .resp_o    (dc_resp),
      .be_req_o  (dc_be_req),
      .be_resp_i (dc_be_resp),
      .inval_i   (inval),
      .hit_o     (dc_hit),
      .miss_o    (dc_miss)
   );

   be_merge be_merge (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .d_req_i      (dc_be_req),
      .i_req_i      (ic_be_req),
      .d_resp_o     (dc_be_resp),
      .i_resp_o     (ic_be_resp),
      .m_req_o      (m_req_o),
      .m_resp_i     (m_resp_i),
      .invalidate_i (invalidate),
      .inval_o      (inval)
   );

endmodule

// ==== design/ext_mem_consts.svh ====
`ifndef EXT_MEM_CONSTS_SVH
`define EXT_MEM_CONSTS_SVH

// Front-end byte address and data word
`define EXT_MEM_ADDR_W 14
`define EXT_MEM_DATA_W 32
`define EXT_MEM_STRB_W (`EXT_MEM_DATA_W / 8)

// Cache geometry, shared by both caches
`define EXT_MEM_INDEX_W 5    // 32 lines
`define EXT_MEM_OFFSET_W 2   // 4 words per line
`define EXT_MEM_BOFF_W 2     // Byte offset in a word

// What is left of the address above the index, space bit excluded
`define EXT_MEM_TAG_W \
   (`EXT_MEM_ADDR_W - 1 - `EXT_MEM_INDEX_W - `EXT_MEM_OFFSET_W - `EXT_MEM_BOFF_W)

`define EXT_MEM_NLINES (1 << `EXT_MEM_INDEX_W)
`define EXT_MEM_NWORDS (1 << `EXT_MEM_OFFSET_W)

// Back-end memory is word addressed
`define EXT_MEM_BE_ADDR_W 12

// Hit and miss counters
`define EXT_MEM_CNT_W 16

`endif

// ==== design/mem_bus_pkg.sv ====
`include "ext_mem_consts.svh"

package mem_bus_pkg;

   // Front-end request from a CPU port
   // A strobe of zero is a read
   typedef struct packed {
      logic                       valid;
      logic [`EXT_MEM_ADDR_W-1:0] addr;    // Byte address
      logic [`EXT_MEM_DATA_W-1:0] wdata;
      logic [`EXT_MEM_STRB_W-1:0] wstrb;
   } fe_req_t;

   // Front-end response, ack is a single-cycle pulse
   typedef struct packed {
      logic                       ack;
      logic [`EXT_MEM_DATA_W-1:0] rdata;
   } fe_resp_t;

   // Back-end request, one word per request
   typedef struct packed {
      logic                          valid;
      logic [`EXT_MEM_BE_ADDR_W-1:0] addr;   // Word address
      logic [`EXT_MEM_DATA_W-1:0]    wdata;
      logic [`EXT_MEM_STRB_W-1:0]    wstrb;
   } be_req_t;

   // Back-end response from memory
   typedef struct packed {
      logic                       ack;
      logic [`EXT_MEM_DATA_W-1:0] rdata;
   } be_resp_t;

endpackage

// ==== design/wt_cache.sv ====
`timescale 1ns/1ps
`include "ext_mem_consts.svh"

module wt_cache (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  mem_bus_pkg::fe_req_t  req_i,
   output mem_bus_pkg::fe_resp_t resp_o,
   output mem_bus_pkg::be_req_t  be_req_o,
   input  mem_bus_pkg::be_resp_t be_resp_i,
   input  logic                  inval_i,
   output logic                  hit_o,
   output logic                  miss_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REFILL,
      S_WRITE,
      S_LOOKUP   // Word read from the array with ack high
   } state_e;

   state_e                       state_q;
   cache_ctrl_pkg::daddr_u       a;
   logic [`EXT_MEM_TAG_W:0]      tag_q [`EXT_MEM_NLINES];   // Space bit kept with the tag
   logic [`EXT_MEM_NLINES-1:0]   valid_q;
   logic [`EXT_MEM_DATA_W-1:0]   data_q [`EXT_MEM_NLINES][`EXT_MEM_NWORDS];
   logic [`EXT_MEM_OFFSET_W-1:0] word_q;   // Refill word counter
   logic                         hit;
   logic                         rd;
   logic                         be_done;

   function automatic logic [`EXT_MEM_DATA_W-1:0] merge_bytes(
      input logic [`EXT_MEM_DATA_W-1:0] old_w,
      input logic [`EXT_MEM_DATA_W-1:0] new_w,
      input logic [`EXT_MEM_STRB_W-1:0] strb
   );
      logic [`EXT_MEM_DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   assign a   = req_i.addr;
   // A line flushed in this very cycle counts as a miss
   assign hit = valid_q[a.mem.index] & ~inval_i &
                (tag_q[a.mem.index] == {a.mem.space, a.mem.tag});
   assign rd  = req_i.valid & ~(|req_i.wstrb);

   // One pulse per read lookup
   assign hit_o  = (state_q == S_IDLE) & rd & hit;
   assign miss_o = (state_q == S_IDLE) & rd & ~hit;

   assign be_done = be_resp_i.ack &
                    ((state_q == S_REFILL) | (state_q == S_WRITE));

   always_comb begin
      be_req_o.valid = (state_q == S_REFILL) | (state_q == S_WRITE);
      if (state_q == S_REFILL) begin
         // Whole line word by word from offset 0
         be_req_o.addr  = {a.mem.space, a.mem.tag, a.mem.index, word_q};
         be_req_o.wdata = '0;
         be_req_o.wstrb = '0;
      end else begin
         be_req_o.addr  = req_i.addr[`EXT_MEM_ADDR_W-1:`EXT_MEM_BOFF_W];
         be_req_o.wdata = req_i.wdata;
         be_req_o.wstrb = req_i.wstrb;
      end
   end

   // Address is held by the master through the ack cycle
   assign resp_o.ack   = (state_q == S_LOOKUP);
   assign resp_o.rdata = data_q[a.mem.index][a.mem.woff];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         word_q  <= '0;
         valid_q <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (req_i.valid) begin
                  if (|req_i.wstrb) begin
                     state_q <= S_WRITE;
                  end else if (hit) begin
                     state_q <= S_LOOKUP;
                  end else begin
                     state_q <= S_REFILL;
                  end
               end
            end
            S_REFILL: begin
               if (be_resp_i.ack) begin
                  word_q <= word_q + 1'b1;   // Wraps back to 0 after the last word
                  if (&word_q) begin
                     valid_q[a.mem.index] <= 1'b1;
                     state_q              <= S_LOOKUP;
                  end
               end
            end
            S_WRITE: begin
               if (be_resp_i.ack) state_q <= S_LOOKUP;
            end
            default: state_q <= S_IDLE;
         endcase

         // Flush all lines
         if (inval_i) valid_q <= '0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (be_done && state_q == S_REFILL) begin
         data_q[a.mem.index][word_q] <= be_resp_i.rdata;
         if (&word_q) tag_q[a.mem.index] <= {a.mem.space, a.mem.tag};
      end
      // Write hit updates the cached word by strobe
      if (be_done && state_q == S_WRITE && hit) begin
         data_q[a.mem.index][a.mem.woff] <=
            merge_bytes(data_q[a.mem.index][a.mem.woff], req_i.wdata, req_i.wstrb);
      end
   end

endmodule

// ==== ext_mem.f ====
+incdir+design
design/mem_bus_pkg.sv
design/cache_ctrl_pkg.sv
design/dbus_decode.sv
design/wt_cache.sv
design/be_merge.sv
design/ext_mem.sv
tb/ext_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary -f ext_mem.f --top-module ext_mem_tb -o ext_mem_sim &&
./obj_dir/ext_mem_sim | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== tb/ext_mem_tb.sv ====
`timescale 1ns/1ps
`include "ext_mem_consts.svh"

module ext_mem_tb;

   localparam int MAX_WAIT = 200;

   logic                  clk;
   logic                  rst;
   mem_bus_pkg::fe_req_t  i_req;
   mem_bus_pkg::fe_req_t  d_req;
   mem_bus_pkg::fe_resp_t i_resp;
   mem_bus_pkg::fe_resp_t d_resp;
   mem_bus_pkg::be_req_t  m_req;
   mem_bus_pkg::be_resp_t m_resp;

   logic [31:0]          mem [4096];   // Back-end memory model
   logic [31:0]          rng;
   mem_bus_pkg::be_req_t be_log [$];   // Served back-end requests
   int                   wait_cnt;
   int                   n_checks;
   int                   n_mismatch;
   int                   n_other;

   ext_mem DUT (
      .clk_i    (clk),
      .rst_i    (rst),
      .i_req_i  (i_req),
      .d_req_i  (d_req),
      .i_resp_o (i_resp),
      .d_resp_o (d_resp),
      .m_req_o  (m_req),
      .m_resp_i (m_resp)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Memory answers after 1 to 4 cycles
   always @(negedge clk) begin
      if (m_resp.ack) begin
         m_resp.ack = 1'b0;
      end else if (!rst && m_req.valid) begin
         if (wait_cnt < 0) begin
            rng      = lcg_next(rng);
            wait_cnt = int'(rng[9:8]);
         end
         if (wait_cnt == 0) begin
            be_log.push_back(m_req);
            m_resp.rdata = mem[m_req.addr];
            for (int b = 0; b < 4; b++) begin
               if (m_req.wstrb[b]) mem[m_req.addr][8*b +: 8] = m_req.wdata[8*b +: 8];
            end
            m_resp.ack = 1'b1;
            wait_cnt   = -1;
         end else begin
            wait_cnt--;
         end
      end
   end

   task automatic port_access(input logic on_i, input mem_bus_pkg::fe_req_t req,
                              output mem_bus_pkg::fe_resp_t resp, output int lat);
      @(negedge clk);
      if (on_i) i_req = req;
      else d_req = req;
      lat  = 0;
      resp = '0;
      while (!resp.ack && lat < MAX_WAIT) begin
         @(negedge clk);
         lat++;
         resp = on_i ? i_resp : d_resp;   // Sampled before valid drops
      end
      if (!resp.ack) begin
         n_other++;
         $display("Error at %0t: no ack on the %s port within %0d cycles", $time,
                  on_i ? "instruction" : "data", MAX_WAIT);
      end
      if (on_i) i_req.valid = 1'b0;
      else d_req.valid = 1'b0;
   endtask

   task automatic check_fe_resp(input string what, input mem_bus_pkg::fe_resp_t got,
                                input mem_bus_pkg::fe_resp_t exp);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH at %0t: %s ack %0b data %h, expected ack %0b data %h",
                  $time, what, got.ack, got.rdata, exp.ack, exp.rdata);
      end
   endtask

   task automatic check_be_req(input string what, input mem_bus_pkg::be_req_t got,
                               input mem_bus_pkg::be_req_t exp);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH at %0t: %s addr %h data %h strb %h, expected %h %h %h",
                  $time, what, got.addr, got.wdata, got.wstrb, exp.addr, exp.wdata,
                  exp.wstrb);
      end
   endtask

   task automatic check_value(input string what, input int got, input int exp);
      n_checks++;
      if (got != exp) begin
         n_mismatch++;
         $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // Four reads from the start of the line
   task automatic check_fills(input int first, input logic [11:0] word);
      mem_bus_pkg::be_req_t exp;
      for (int k = 0; k < 4; k++) begin
         exp.valid = 1'b1;
         exp.addr  = {word[11:2], 2'b00} + 12'(k);
         exp.wdata = '0;
         exp.wstrb = '0;
         if (first + k < be_log.size()) check_be_req("line fill", be_log[first + k], exp);
      end
   endtask

   task automatic check_read(input string what, input logic [13:0] addr,
                             input mem_bus_pkg::fe_resp_t got);
      mem_bus_pkg::fe_resp_t exp;
      exp.ack   = 1'b1;
      exp.rdata = mem[addr[13:2]];
      check_fe_resp(what, got, exp);
   endtask

   initial begin
      int                    fd;
      string                 line;
      logic [7:0]            port_c;
      logic [7:0]            op_c;
      logic [31:0]           addr;
      logic [31:0]           data;
      logic [31:0]           strb;
      int                    exp_n;
      int                    lat;
      int                    lat2;
      mem_bus_pkg::fe_req_t  req;
      mem_bus_pkg::fe_req_t  req2;
      mem_bus_pkg::fe_resp_t resp;
      mem_bus_pkg::fe_resp_t resp2;
      mem_bus_pkg::be_req_t  exp_be;
      i_req      = '0;
      d_req      = '0;
      m_resp     = '0;
      rst        = 1'b1;
      wait_cnt   = -1;
      n_checks   = 0;
      n_mismatch = 0;
      n_other    = 0;
      rng        = 32'h298e72d6;
      for (int i = 0; i < 4096; i++) begin
         rng    = lcg_next(rng);
         mem[i] = rng ^ {20'h0, 12'(i)};
      end
      repeat (2) @(negedge clk);
      rst = 1'b0;
      fd  = $fopen("tb/ext_mem_tests.txt", "r");
      if (fd == 0) begin
         n_other++;
         $display("Error: could not open tb/ext_mem_tests.txt");
      end else begin
         while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            if ($sscanf(line, "%s %s %h %h %h %d", port_c, op_c, addr, data, strb,
                        exp_n) != 6) begin
               n_other++;
               $display("Error: badly formed test line: %s", line);
               continue;
            end
            req.valid = 1'b1;
            req.addr  = addr[13:0];
            req.wdata = data;
            req.wstrb = strb[3:0];
            be_log.delete();
            if (port_c == "P") begin
               req2      = req;
               req2.addr = data[13:0];
               req2.wdata = '0;
               fork
                  port_access(1'b0, req, resp, lat);
                  port_access(1'b1, req2, resp2, lat2);
               join
               check_value("back-end reads", be_log.size(), 2 * exp_n);
               check_fills(0, addr[13:2]);   // Data cache first
               check_fills(4, data[13:2]);
               check_read("data read", addr[13:0], resp);
               check_read("instruction read", data[13:0], resp2);
            end else begin
               port_access(port_c == "I", req, resp, lat);
               if (addr[13]) begin
                  check_value("control latency", lat, 1);
                  check_value("back-end requests", be_log.size(), 0);
                  if (op_c == "R") begin
                     resp2.ack   = 1'b1;
                     resp2.rdata = 32'(exp_n);
                     check_fe_resp("counter read", resp, resp2);
                  end
               end else if (op_c == "W") begin
                  check_value("back-end writes", be_log.size(), 1);
                  exp_be.valid = 1'b1;
                  exp_be.addr  = addr[13:2];
                  exp_be.wdata = data;
                  exp_be.wstrb = strb[3:0];
                  if (be_log.size() > 0) check_be_req("write through", be_log[0], exp_be);
               end else begin
                  check_value("back-end reads", be_log.size(), exp_n);
                  if (exp_n == 0) check_value("hit latency", lat, 1);
                  else check_fills(0, addr[13:2]);
                  check_read("read", addr[13:0], resp);
               end
            end
         end
         $fclose(fd);
      end
      $display("Checks: %0d, mismatches: %0d, other errors: %0d", n_checks, n_mismatch,
               n_other);
      if (n_mismatch == 0 && n_other == 0 && n_checks > 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== tb/ext_mem_tests.txt ====
# port(I/D/P) op(R/W) addr(hex) data(hex) strobe(hex) expect(dec)
# P runs a data read at addr and an instruction read at data together
D R 0040 0 0 4
D R 0044 0 0 0
I R 0040 0 0 4
I R 0044 0 0 0
D W 0048 a5a5a5a5 3 0
D R 0048 0 0 0
D W 0200 12345678 f 0
D R 0200 0 0 4
D W 2000 0 f 0
I R 0048 0 0 4
D R 0044 0 0 4
D R 2004 0 0 2
D R 2008 0 0 3
P R 0300 0700 0 4
D R 0304 0 0 0
I R 0704 0 0 0
D R 2004 0 0 3
D R 2008 0 0 4
